//--- verilog/bpClassPkg.sv
package bpClassPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction class word
  ////////////////////////////////////////////////////////////////////////////

  // One-hot class word as produced by the target buffer and the decoder
  localparam int classWidth = 5;

  // Bit positions in the class word
  // Only the conditional branch bit steers the direction predictor
  localparam int classBranch  = 0;
  localparam int classJump    = 1;
  localparam int classJumpReg = 2;
  localparam int classCall    = 3;
  localparam int classReturn  = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Two-bit saturating counter states
  ////////////////////////////////////////////////////////////////////////////

  // Bit 1 is the predicted direction
  localparam logic [1:0] ctrStrongNot   = 2'b00;
  localparam logic [1:0] ctrWeakNot     = 2'b01;
  localparam logic [1:0] ctrWeakTaken   = 2'b10;
  localparam logic [1:0] ctrStrongTaken = 2'b11;

endpackage

//--- verilog/bpConfigPkg.sv
package bpConfigPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Predictor sizing
  ////////////////////////////////////////////////////////////////////////////

  // Global history length in bits
  // The table holds 2**defaultHistoryBits counters
  localparam int defaultHistoryBits = 10;

  // Width of one table entry
  localparam int counterBits = 2;

endpackage

//--- verilog/phtRam.sv
`timescale 1ns/1ps

module phtRam #(
  parameter int historyBits = 10
) (
  input  logic                                clk,
  input  logic                                rstN,
  input  logic [historyBits-1:0]              readAdr,
  input  logic                                readEn,
  output logic [bpConfigPkg::counterBits-1:0] readData,
  input  logic [historyBits-1:0]              writeAdr,
  input  logic                                writeEn,
  input  logic [bpConfigPkg::counterBits-1:0] writeData
);
  import bpConfigPkg::*;
  import bpClassPkg::*;

  // One counter per history pattern
  localparam int tableDepth = 1 << historyBits;

  logic [counterBits-1:0] ctrTable [tableDepth];

  // Write port
  // All entries start weakly not-taken
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < tableDepth; i++) begin
        ctrTable[i] <= ctrWeakNot;
      end
    end else if (writeEn) begin
      ctrTable[writeAdr] <= writeData;
    end
  end

  // Registered read port
  // Holds the last value while readEn is low
  // Same-edge write is not visible until the next read
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      readData <= ctrWeakNot;
    end else if (readEn) begin
      readData <= ctrTable[readAdr];
    end
  end

endmodule

//--- verilog/counterUpdate.sv
`timescale 1ns/1ps

module counterUpdate (
  input  logic [bpConfigPkg::counterBits-1:0] BPPredE,
  input  logic [bpClassPkg::classWidth-1:0]   InstrClassE,
  input  logic                                PCSrcE,
  output logic                                BPPredDirWrongE,
  output logic [bpConfigPkg::counterBits-1:0] UpdateBPPredE
);
  import bpClassPkg::*;

  // Direction miss only counts for a real conditional branch
  assign BPPredDirWrongE = InstrClassE[classBranch] & (BPPredE[1] ^ PCSrcE);

  ////////////////////////////////////////////////////////////////////////////
  // Saturating step toward the outcome
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (BPPredE)
      ctrStrongNot: begin
        UpdateBPPredE = PCSrcE ? ctrWeakNot : ctrStrongNot;
      end
      ctrWeakNot: begin
        UpdateBPPredE = PCSrcE ? ctrWeakTaken : ctrStrongNot;
      end
      ctrWeakTaken: begin
        UpdateBPPredE = PCSrcE ? ctrStrongTaken : ctrWeakNot;
      end
      ctrStrongTaken: begin
        UpdateBPPredE = PCSrcE ? ctrStrongTaken : ctrWeakTaken;
      end
      // Unreachable with a 2-bit counter
      default: begin
        UpdateBPPredE = ctrWeakNot;
      end
    endcase
  end

endmodule

//--- verilog/predPipeline.sv
`timescale 1ns/1ps

module predPipeline (
  input  logic                                clk,
  input  logic                                rstN,
  input  logic                                StallD,
  input  logic                                StallE,
  input  logic                                FlushD,
  input  logic                                FlushE,
  input  logic [bpConfigPkg::counterBits-1:0] BPPredF,
  input  logic [bpClassPkg::classWidth-1:0]   BPInstrClassF,
  output logic [bpConfigPkg::counterBits-1:0] BPPredD,
  output logic [bpConfigPkg::counterBits-1:0] BPPredE,
  output logic [bpClassPkg::classWidth-1:0]   BPInstrClassD,
  output logic [bpClassPkg::classWidth-1:0]   BPInstrClassE
);
  import bpClassPkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Fetch to Decode
  ////////////////////////////////////////////////////////////////////////////

  // Flush has priority over stall
  // A flushed slot looks like a non-branch with a neutral counter
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      BPInstrClassD <= '0;
      BPPredD       <= ctrWeakNot;
    end else if (FlushD) begin
      BPInstrClassD <= '0;
      BPPredD       <= ctrWeakNot;
    end else if (!StallD) begin
      BPInstrClassD <= BPInstrClassF;
      BPPredD       <= BPPredF;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Decode to Execute
  ////////////////////////////////////////////////////////////////////////////

  // Counter stays paired with its instruction for training in Execute
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      BPInstrClassE <= '0;
      BPPredE       <= ctrWeakNot;
    end else if (FlushE) begin
      BPInstrClassE <= '0;
      BPPredE       <= ctrWeakNot;
    end else if (!StallE) begin
      BPInstrClassE <= BPInstrClassD;
      BPPredE       <= BPPredD;
    end
  end

endmodule

//--- verilog/globalHistoryPredictor.sv
`timescale 1ns/1ps

module globalHistoryPredictor #(
  parameter int historyBits = 10
) (
  input  logic                                clk,
  input  logic                                rstN,
  input  logic                                StallF,
  input  logic                                StallE,
  input  logic [bpClassPkg::classWidth-1:0]   BPInstrClassF,
  input  logic [bpClassPkg::classWidth-1:0]   BPInstrClassD,
  input  logic [bpClassPkg::classWidth-1:0]   BPInstrClassE,
  input  logic [bpClassPkg::classWidth-1:0]   InstrClassE,
  input  logic                                BPPredDirWrongE,
  input  logic                                PCSrcE,
  input  logic [bpConfigPkg::counterBits-1:0] UpdateBPPredE,
  output logic [bpConfigPkg::counterBits-1:0] BPPredF
);
  import bpClassPkg::*;

  // Two spare bits so up to two speculative shifts can be undone
  logic [historyBits+1:0] historyReg;
  logic [historyBits+1:0] historyNext;
  logic                   historyEn;
  logic [6:0]             muxSel;

  logic [historyBits-1:0] lookupAdr;
  logic [historyBits-1:0] updateAdr;
  logic [historyBits-1:0] updateAdrNoD;
  logic [historyBits-1:0] updateAdrWithD;
  logic                   updateEn;

  // Branch bits of each stage
  logic predBranchF;
  logic predBranchD;
  logic predBranchE;
  logic realBranchE;

  // Execute outcome against the prediction
  logic classRightNonCfi;
  logic classWrongCfi;
  logic classWrongNonCfi;
  logic classRightDirWrong;
  logic classRightDirRight;

  assign predBranchF = BPInstrClassF[classBranch];
  assign predBranchD = BPInstrClassD[classBranch];
  assign predBranchE = BPInstrClassE[classBranch];
  assign realBranchE = InstrClassE[classBranch];

  ////////////////////////////////////////////////////////////////////////////
  // Resolution classes
  ////////////////////////////////////////////////////////////////////////////

  // Exactly one of these five is true each cycle
  assign classRightNonCfi   = ~predBranchE & ~realBranchE;
  assign classWrongCfi      = ~predBranchE &  realBranchE;
  assign classWrongNonCfi   =  predBranchE & ~realBranchE;
  assign classRightDirWrong =  predBranchE &  realBranchE &  BPPredDirWrongE;
  assign classRightDirRight =  predBranchE &  realBranchE & ~BPPredDirWrongE;

  // One-hot history select
  // Decode predicted branch means one extra speculative bit sits above Execute
  assign muxSel[0] = ~predBranchF & (classRightNonCfi | classRightDirRight);
  assign muxSel[1] = classWrongCfi & ~predBranchD;
  assign muxSel[2] = classWrongNonCfi & ~predBranchD;
  assign muxSel[3] = (classRightDirWrong & ~predBranchD) | (classWrongCfi & predBranchD);
  assign muxSel[4] = classWrongNonCfi & predBranchD;
  assign muxSel[5] = classRightDirWrong & predBranchD;
  assign muxSel[6] = predBranchF & (classRightNonCfi | classRightDirRight);

  // Repairs follow Execute
  // The speculative shift follows Fetch
  assign historyEn = ((|muxSel[5:1]) & ~StallE) | (muxSel[6] & ~StallF);

  ////////////////////////////////////////////////////////////////////////////
  // History update and register
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (muxSel)
      // no change
      7'b000_0001: historyNext = historyReg;
      // late branch found in Execute
      7'b000_0010: historyNext = {historyReg[historyBits:0], PCSrcE};
      // repair 1
      7'b000_0100: historyNext = {1'b0, historyReg[historyBits+1:1]};
      // Newest bit was wrong so overwrite it
      7'b000_1000: historyNext = {historyReg[historyBits+1:1], PCSrcE};
      // repair 2
      7'b001_0000: historyNext = {2'b00, historyReg[historyBits+1:2]};
      // Drop the Decode bit and fix the Execute bit
      7'b010_0000: historyNext = {1'b0, historyReg[historyBits+1:2], PCSrcE};
      // Speculative shift of the Fetch prediction
      7'b100_0000: historyNext = {historyReg[historyBits:0], BPPredF[1]};
      default:     historyNext = historyReg;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      historyReg <= '0;
    end else if (historyEn) begin
      historyReg <= historyNext;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Table addressing
  ////////////////////////////////////////////////////////////////////////////

  // Forward the next history into the lookup when a new one is selected
  assign lookupAdr = (|muxSel[6:1]) ? historyNext[historyBits-1:0]
                                    : historyReg[historyBits-1:0];

  // Skip the bits shifted in by younger speculative branches
  assign updateAdrNoD   = realBranchE ? historyReg[historyBits:1]
                                      : historyReg[historyBits-1:0];
  assign updateAdrWithD = realBranchE ? historyReg[historyBits+1:2]
                                      : historyReg[historyBits:1];
  assign updateAdr      = predBranchD ? updateAdrWithD : updateAdrNoD;

  // Train only on real conditional branches
  assign updateEn = realBranchE & ~StallE;

  phtRam #(
    .historyBits (historyBits)
  ) pht (
    .clk       (clk),
    .rstN      (rstN),
    .readAdr   (lookupAdr),
    .readEn    (~StallF),
    .readData  (BPPredF),
    .writeAdr  (updateAdr),
    .writeEn   (updateEn),
    .writeData (UpdateBPPredE)
  );

endmodule

//--- verilog/branchPredictorTop.sv
`timescale 1ns/1ps

module branchPredictorTop #(
  parameter int historyBits = bpConfigPkg::defaultHistoryBits
) (
  input  logic                                clk,
  input  logic                                rstN,
  input  logic                                StallF,
  input  logic                                StallD,
  input  logic                                StallE,
  input  logic                                FlushD,
  input  logic                                FlushE,
  input  logic [bpClassPkg::classWidth-1:0]   BPInstrClassF,
  input  logic [bpClassPkg::classWidth-1:0]   InstrClassE,
  input  logic                                PCSrcE,
  output logic [bpConfigPkg::counterBits-1:0] BPPredF,
  output logic [bpClassPkg::classWidth-1:0]   BPInstrClassD,
  output logic [bpClassPkg::classWidth-1:0]   BPInstrClassE,
  output logic                                BPPredDirWrongE
);

  // Execute-stage counter and its trained value
  logic [bpConfigPkg::counterBits-1:0] BPPredE;
  logic [bpConfigPkg::counterBits-1:0] UpdateBPPredE;

  ////////////////////////////////////////////////////////////////////////////
  // Stage registers
  ////////////////////////////////////////////////////////////////////////////

  // Decode-stage counter is only consumed inside the pipeline
  predPipeline pipe (
    .clk           (clk),
    .rstN          (rstN),
    .StallD        (StallD),
    .StallE        (StallE),
    .FlushD        (FlushD),
    .FlushE        (FlushE),
    .BPPredF       (BPPredF),
    .BPInstrClassF (BPInstrClassF),
    .BPPredD       (),
    .BPPredE       (BPPredE),
    .BPInstrClassD (BPInstrClassD),
    .BPInstrClassE (BPInstrClassE)
  );

  // Execute resolution
  counterUpdate resolve (
    .BPPredE         (BPPredE),
    .InstrClassE     (InstrClassE),
    .PCSrcE          (PCSrcE),
    .BPPredDirWrongE (BPPredDirWrongE),
    .UpdateBPPredE   (UpdateBPPredE)
  );

  ////////////////////////////////////////////////////////////////////////////
  // History and table
  ////////////////////////////////////////////////////////////////////////////

  globalHistoryPredictor #(
    .historyBits (historyBits)
  ) ghp (
    .clk             (clk),
    .rstN            (rstN),
    .StallF          (StallF),
    .StallE          (StallE),
    .BPInstrClassF   (BPInstrClassF),
    .BPInstrClassD   (BPInstrClassD),
    .BPInstrClassE   (BPInstrClassE),
    .InstrClassE     (InstrClassE),
    .BPPredDirWrongE (BPPredDirWrongE),
    .PCSrcE          (PCSrcE),
    .UpdateBPPredE   (UpdateBPPredE),
    .BPPredF         (BPPredF)
  );

endmodule

//--- include/bpRefModel.svh
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

// History length used by the model and the DUT under test
localparam int modelHistoryBits = 6;

// Model state mirrors history, table and stage registers
logic [modelHistoryBits+1:0] mHistory;
logic [1:0]                  mTable [1 << modelHistoryBits];
logic [1:0]                  mPredF;
logic [1:0]                  mPredD;
logic [1:0]                  mPredE;
logic [4:0]                  mClassD;
logic [4:0]                  mClassE;

// Saturating counter step
function automatic logic [1:0] modelStep(input logic [1:0] ctr, input logic taken);
  if (taken) begin
    return (ctr == bpClassPkg::ctrStrongTaken) ? ctr : ctr + 2'd1;
  end
  return (ctr == bpClassPkg::ctrStrongNot) ? ctr : ctr - 2'd1;
endfunction

// Expected direction miss from current Execute state
function automatic logic modelDirWrong(input logic [4:0] realClass, input logic taken);
  return realClass[bpClassPkg::classBranch] & (mPredE[1] ^ taken);
endfunction

task automatic modelReset();
  mHistory = '0;
  for (int i = 0; i < (1 << modelHistoryBits); i++) begin
    mTable[i] = bpClassPkg::ctrWeakNot;
  end
  mPredF  = bpClassPkg::ctrWeakNot;
  mPredD  = bpClassPkg::ctrWeakNot;
  mPredE  = bpClassPkg::ctrWeakNot;
  mClassD = '0;
  mClassE = '0;
endtask

// One rising edge with the inputs sampled before it
task automatic modelClock(input logic stallF, input logic stallD, input logic stallE,
                          input logic flushD, input logic flushE, input logic [4:0] classF,
                          input logic [4:0] realClass, input logic taken);
  logic                        pF;
  logic                        pD;
  logic                        pE;
  logic                        rE;
  logic                        wrong;
  int                          sel;
  int                          offset;
  logic [modelHistoryBits+1:0] next;
  logic [modelHistoryBits-1:0] lookup;
  logic [1:0]                  readVal;
  pF    = classF[bpClassPkg::classBranch];
  pD    = mClassD[bpClassPkg::classBranch];
  pE    = mClassE[bpClassPkg::classBranch];
  rE    = realClass[bpClassPkg::classBranch];
  wrong = modelDirWrong(realClass, taken);
  // Select number matches the one-hot position
  if (pE == rE && !(rE && wrong)) sel = pF ? 6 : 0;
  else if (!pE && rE) sel = pD ? 3 : 1;
  else if (pE && !rE) sel = pD ? 4 : 2;
  else sel = pD ? 5 : 3;
  case (sel)
    1: next = {mHistory[modelHistoryBits:0], taken};
    2: next = {1'b0, mHistory[modelHistoryBits+1:1]};
    3: next = {mHistory[modelHistoryBits+1:1], taken};
    4: next = {2'b00, mHistory[modelHistoryBits+1:2]};
    5: next = {1'b0, mHistory[modelHistoryBits+1:2], taken};
    6: next = {mHistory[modelHistoryBits:0], mPredF[1]};
    default: next = mHistory;
  endcase
  lookup  = (sel != 0) ? next[modelHistoryBits-1:0] : mHistory[modelHistoryBits-1:0];
  readVal = mTable[lookup];
  offset  = int'(rE) + int'(pD);
  if (rE && !stallE) mTable[mHistory[offset +: modelHistoryBits]] = modelStep(mPredE, taken);
  if ((sel >= 1 && sel <= 5 && !stallE) || (sel == 6 && !stallF)) mHistory = next;
  // Execute stage first so it sees the old Decode values
  if (flushE) begin
    mClassE = '0;
    mPredE  = bpClassPkg::ctrWeakNot;
  end else if (!stallE) begin
    mClassE = mClassD;
    mPredE  = mPredD;
  end
  if (flushD) begin
    mClassD = '0;
    mPredD  = bpClassPkg::ctrWeakNot;
  end else if (!stallD) begin
    mClassD = classF;
    mPredD  = mPredF;
  end
  if (!stallF) mPredF = readVal;
endtask

`endif

//--- test/tbBranchPredictor.sv
`timescale 1ns/1ps

module tbBranchPredictor;
  import bpClassPkg::*;

  // Cycle budget of reset and all five tests, used by the watchdog
  localparam int resetCycles = 8;
  localparam int totalCycles = resetCycles + 1 + 4 + 30 + 200 + 80 + 3000;
  localparam int timeoutNs   = totalCycles * 10 + 200;

  logic       clk = 1'b0;
  logic       rstN;
  logic       StallF;
  logic       StallD;
  logic       StallE;
  logic       FlushD;
  logic       FlushE;
  logic [4:0] BPInstrClassF;
  logic [4:0] InstrClassE;
  logic       PCSrcE;
  logic [1:0] BPPredF;
  logic [4:0] BPInstrClassD;
  logic [4:0] BPInstrClassE;
  logic       BPPredDirWrongE;

  integer     seed = 32'hf2c2f1db;
  int         errorCount = 0;
  int         checkCount = 0;
  int         testsFailed = 0;
  int         startErrors;
  int         wrongSeen;
  logic [4:0] heldD;
  logic [4:0] heldE;

  `include "bpRefModel.svh"

  // Small table so that histories alias often
  branchPredictorTop #(.historyBits(modelHistoryBits)) DUT (.*);

  always #5 clk = ~clk;

  // Watchdog
  initial begin
    #(timeoutNs);
    $display("Watchdog timeout: the run did not finish in the expected time");
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkValue(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    checkCount++;
    assert (actual === expected) else begin
      $display("[ERROR] time %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic driveIdle();
    StallF        = 1'b0;
    StallD        = 1'b0;
    StallE        = 1'b0;
    FlushD        = 1'b0;
    FlushE        = 1'b0;
    BPInstrClassF = '0;
    InstrClassE   = '0;
    PCSrcE        = 1'b0;
  endtask

  // Inputs already driven; model steps on the rising edge
  // DUT outputs compared at the falling edge where they are stable
  task automatic runCycle();
    @(posedge clk);
    modelClock(StallF, StallD, StallE, FlushD, FlushE, BPInstrClassF, InstrClassE, PCSrcE);
    @(negedge clk);
    checkValue("BPPredF", mPredF, BPPredF);
    checkValue("BPInstrClassD", mClassD, BPInstrClassD);
    checkValue("BPInstrClassE", mClassE, BPInstrClassE);
    checkValue("BPPredDirWrongE", modelDirWrong(InstrClassE, PCSrcE), BPPredDirWrongE);
  endtask

  // Real branch bit agrees with the Execute prediction 7 times in 8
  task automatic randomCycle(input logic withStalls);
    logic [31:0] r;
    logic        realBit;
    r = $random(seed);
    BPInstrClassF = '0;
    BPInstrClassF[classBranch] = r[0];
    realBit = (r[4:2] != 3'b000) ? BPInstrClassE[classBranch] : ~BPInstrClassE[classBranch];
    InstrClassE = '0;
    InstrClassE[classBranch] = realBit;
    PCSrcE = r[5];
    // Rare stalls and rarer flushes
    StallF = withStalls && (r[9:6] == 4'd0);
    StallD = withStalls && (r[13:10] == 4'd0);
    StallE = withStalls && (r[17:14] == 4'd0);
    FlushD = withStalls && (r[22:18] == 5'd0);
    FlushE = withStalls && (r[27:23] == 5'd0);
    runCycle();
  endtask

  task automatic finishTest(input string name);
    if (errorCount == startErrors) begin
      $display("%s: PASS", name);
    end else begin
      testsFailed++;
      $display("%s: FAIL with %0d errors", name, errorCount - startErrors);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rstN = 1'b0;
    driveIdle();
    modelReset();
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    // Reset state, first reads hit untouched entries
    startErrors = errorCount;
    checkValue("BPPredF", ctrWeakNot, BPPredF);
    checkValue("BPInstrClassD", 5'd0, BPInstrClassD);
    checkValue("BPInstrClassE", 5'd0, BPInstrClassE);
    checkValue("BPPredDirWrongE", 1'b0, BPPredDirWrongE);
    repeat (4) begin
      runCycle();
      checkValue("BPPredF", ctrWeakNot, BPPredF);
    end
    finishTest("Test 1 reset state");

    // Free flow, one and two cycle delay
    startErrors = errorCount;
    for (int i = 0; i < 20; i++) begin
      heldE = BPInstrClassF;
      BPInstrClassF = 5'($random(seed));
      runCycle();
      checkValue("BPInstrClassD", BPInstrClassF, BPInstrClassD);
      checkValue("BPInstrClassE", heldE, BPInstrClassE);
    end
    // Stalls hold both stages
    heldD = BPInstrClassD;
    heldE = BPInstrClassE;
    StallD = 1'b1;
    StallE = 1'b1;
    repeat (4) begin
      BPInstrClassF = 5'($random(seed));
      runCycle();
      checkValue("BPInstrClassD", heldD, BPInstrClassD);
      checkValue("BPInstrClassE", heldE, BPInstrClassE);
    end
    // Flush beats stall
    FlushD = 1'b1;
    FlushE = 1'b1;
    repeat (2) begin
      runCycle();
      checkValue("BPInstrClassD", 5'd0, BPInstrClassD);
      checkValue("BPInstrClassE", 5'd0, BPInstrClassE);
    end
    driveIdle();
    repeat (4) runCycle();
    finishTest("Test 2 pipeline transport");

    // Unstalled random traffic with some direction misses
    startErrors = errorCount;
    wrongSeen = 0;
    repeat (200) begin
      randomCycle(1'b0);
      if (modelDirWrong(InstrClassE, PCSrcE)) wrongSeen++;
    end
    assert (wrongSeen > 0) else begin
      $display("Direction test never produced a mispredicted branch");
      errorCount++;
    end
    finishTest("Test 3 direction resolution");

    // Late branches only, history fills with the outcome and then stays
    // All ones trains entry 63, all zeros trains entry 0
    startErrors = errorCount;
    driveIdle();
    InstrClassE[classBranch] = 1'b1;
    PCSrcE = 1'b1;
    for (int i = 0; i < 40; i++) begin
      runCycle();
      if (i >= 32) checkValue("BPPredF", ctrStrongTaken, BPPredF);
    end
    PCSrcE = 1'b0;
    for (int i = 0; i < 40; i++) begin
      runCycle();
      if (i >= 32) checkValue("BPPredF", ctrStrongNot, BPPredF);
    end
    finishTest("Test 4 training and saturation");

    // Full mix of class and direction misses with stalls and flushes
    startErrors = errorCount;
    repeat (3000) randomCycle(1'b1);
    finishTest("Test 5 speculation and repair");

    $display("Summary: 5 tests run, %0d failed, %0d checks, %0d errors",
             testsFailed, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+include
verilog/bpClassPkg.sv
verilog/bpConfigPkg.sv
verilog/phtRam.sv
verilog/counterUpdate.sv
verilog/predPipeline.sv
verilog/globalHistoryPredictor.sv
verilog/branchPredictorTop.sv
test/tbBranchPredictor.sv
